// File: hw/adpcmb_pkg.sv
//**********************************************************************
// Shared definitions for the ADPCM-B playback channel. Holds widths,
// the APB register map, step-size constants, bus and config structs
// and the playback FSM encoding. Imported by every RTL module.
//**********************************************************************
`default_nettype none

package adpcmb_pkg;

    // Widths with a meaning
    typedef logic [15:0]        addr_t;          // Byte address into sample memory
    typedef logic [16:0]        nibble_addr_t;   // Byte address plus low-nibble select
    typedef logic signed [15:0] pcm_t;           // Decoded sample
    typedef logic [15:0]        step_t;          // Adaptive step size
    typedef logic [15:0]        delta_n_t;       // Pitch increment
    typedef logic [15:0]        rate_t;          // Tick divider
    typedef logic [3:0]         nibble_t;        // ADPCM code

    // APB register offsets
    localparam logic [7:0] REG_CTRL    = 8'h00;
    localparam logic [7:0] REG_PAN     = 8'h04;
    localparam logic [7:0] REG_START   = 8'h08;
    localparam logic [7:0] REG_END     = 8'h0C;
    localparam logic [7:0] REG_DELTA_N = 8'h10;
    localparam logic [7:0] REG_RATE    = 8'h14;
    localparam logic [7:0] REG_STATUS  = 8'h18;

    // CTRL bit positions
    localparam int CTRL_START_BIT  = 0;
    localparam int CTRL_REPEAT_BIT = 1;
    localparam int CTRL_STOP_BIT   = 2;

    localparam rate_t RATE_MIN = 16'd8;     // Keeps one nibble in flight at most

    // Delta-T step adaptation
    localparam step_t STEP_INIT = 16'd127;
    localparam step_t STEP_MIN  = 16'd127;
    localparam step_t STEP_MAX  = 16'd24576;

    // Step multipliers over 64, indexed by the 3 magnitude bits
    localparam logic [7:0][7:0] STEP_MULT = {
        8'd153, 8'd128, 8'd102, 8'd77,
        8'd57,  8'd57,  8'd57,  8'd57
    };

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [15:0] pwdata;
    } apb_req_s;

    typedef struct packed {
        logic [15:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_s;

    typedef struct packed {
        addr_t      start_addr;
        addr_t      end_addr;
        delta_n_t   delta_n;
        rate_t      rate;
        logic       repeat_en;
        logic [1:0] pan;        // Bit 1 left, bit 0 right
    } chan_cfg_s;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_STEP,
        READ,
        LATCH,
        DECODE
    } play_state_e;

endpackage

`default_nettype wire

// File: hw/adpcmb_regs.sv
//**********************************************************************
// APB slave for the channel. Holds the configuration registers,
// turns CTRL writes into start and stop pulses and keeps the sticky
// end-of-sample flag that STATUS reports with the busy bit.
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module adpcmb_regs
    import adpcmb_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire apb_req_s  apb_req,
    output apb_rsp_s       apb_rsp,
    input  wire logic      busy,
    input  wire logic      end_flag_set,
    output chan_cfg_s      cfg,
    output logic           cmd_start,
    output logic           cmd_stop
);

    logic access;       // Access phase of any transfer
    logic wr_en;
    logic wr_ctrl;
    logic mapped;
    logic end_flag;

    assign access  = apb_req.psel & apb_req.penable;
    assign wr_en   = access & apb_req.pwrite;
    assign wr_ctrl = wr_en & (apb_req.paddr == REG_CTRL);

    // Command pulses last the single access cycle, stop wins
    assign cmd_stop  = wr_ctrl & apb_req.pwdata[CTRL_STOP_BIT];
    assign cmd_start = wr_ctrl & apb_req.pwdata[CTRL_START_BIT] &
                       ~apb_req.pwdata[CTRL_STOP_BIT];

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg <= '0;
        end else if (wr_en) begin
            case (apb_req.paddr)
                REG_CTRL:    cfg.repeat_en  <= apb_req.pwdata[CTRL_REPEAT_BIT];
                REG_PAN:     cfg.pan        <= apb_req.pwdata[1:0];
                REG_START:   cfg.start_addr <= apb_req.pwdata;
                REG_END:     cfg.end_addr   <= apb_req.pwdata;
                REG_DELTA_N: cfg.delta_n    <= apb_req.pwdata;
                REG_RATE:    cfg.rate       <= apb_req.pwdata;
                default: ;                                  // Unmapped, dropped
            endcase
        end
    end

    // Sticky until the next start
    always_ff @(posedge clk) begin
        if (rst || cmd_start) begin
            end_flag <= 1'b0;
        end else if (end_flag_set) begin
            end_flag <= 1'b1;
        end
    end

    always_comb begin
        mapped         = 1'b1;
        apb_rsp.prdata = '0;
        case (apb_req.paddr)
            REG_CTRL:    apb_rsp.prdata[CTRL_REPEAT_BIT] = cfg.repeat_en;
            REG_PAN:     apb_rsp.prdata[1:0] = cfg.pan;
            REG_START:   apb_rsp.prdata = cfg.start_addr;
            REG_END:     apb_rsp.prdata = cfg.end_addr;
            REG_DELTA_N: apb_rsp.prdata = cfg.delta_n;
            REG_RATE:    apb_rsp.prdata = cfg.rate;
            REG_STATUS:  apb_rsp.prdata[1:0] = {end_flag, busy};
            default:     mapped = 1'b0;
        endcase
    end

    assign apb_rsp.pready = 1'b1;                           // Never stalls
    assign apb_rsp.pslverr = access &
                             (~mapped | (apb_req.pwrite & (apb_req.paddr == REG_STATUS)));

endmodule

`default_nettype wire

// File: hw/adpcmb_step_timer.sv
//**********************************************************************
// Sample tick divider and Delta-N phase accumulator. tick pulses every
// rate cycles while the channel plays. step_req marks the tick whose
// phase addition carries, which asks for the next nibble.
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module adpcmb_step_timer
    import adpcmb_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire rate_t    rate,
    input  wire delta_n_t delta_n,
    input  wire logic     busy,
    input  wire logic     cmd_start,
    output logic          tick,
    output logic          step_req
);

    rate_t    rate_eff;     // Divider held at the floor
    rate_t    cnt;
    delta_n_t phase;

    assign rate_eff = (rate < RATE_MIN) ? RATE_MIN : rate;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt      <= '0;
            phase    <= '0;
            tick     <= 1'b0;
            step_req <= 1'b0;
        end else if (cmd_start) begin
            cnt      <= rate_eff - 1'b1;                    // First tick a full period out
            phase    <= '0;
            tick     <= 1'b0;
            step_req <= 1'b0;
        end else if (busy && cnt == '0) begin
            cnt               <= rate_eff - 1'b1;
            tick              <= 1'b1;
            {step_req, phase} <= {1'b0, phase} + {1'b0, delta_n};   // Carry asks for a step
        end else begin
            if (busy) begin
                cnt <= cnt - 1'b1;
            end
            tick     <= 1'b0;
            step_req <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: hw/adpcmb_addr_gen.sv
//**********************************************************************
// Nibble address counter. Loads the high nibble of the start byte,
// steps one nibble per advance and flags the low nibble of the end
// byte. Advancing past the end wraps back to the start.
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module adpcmb_addr_gen
    import adpcmb_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire addr_t start_addr,
    input  wire addr_t end_addr,
    input  wire logic  load,
    input  wire logic  adv,
    output addr_t      mem_addr,
    output logic       low_nib,
    output logic       last
);

    nibble_addr_t nib_addr;
    nibble_addr_t start_nib;
    nibble_addr_t end_nib;

    assign start_nib = {start_addr, 1'b0};      // High nibble plays first
    assign end_nib   = {end_addr, 1'b1};

    assign last     = (nib_addr == end_nib);
    assign mem_addr = nib_addr[16:1];
    assign low_nib  = nib_addr[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            nib_addr <= '0;
        end else if (load) begin
            nib_addr <= start_nib;
        end else if (adv) begin
            // Wrap at the end, the FSM decides whether to keep going
            nib_addr <= last ? start_nib : nib_addr + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/adpcmb_ctrl.sv
//**********************************************************************
// Playback FSM. One nibble fetch per step request: read the byte,
// latch the nibble, then strobe the decoder and the address counter.
// Handles end of sample by restarting or stopping the channel.
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module adpcmb_ctrl
    import adpcmb_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic cmd_start,
    input  wire logic cmd_stop,
    input  wire logic repeat_en,
    input  wire logic step_req,
    input  wire logic last,
    output logic      busy,
    output logic      mem_rd,
    output logic      latch,
    output logic      dec_en,
    output logic      dec_clr,
    output logic      addr_load,
    output logic      addr_adv,
    output logic      end_flag_set
);

    play_state_e state;
    play_state_e state_nxt;
    logic        at_end;    // Decoding the final nibble

    assign at_end = (state == DECODE) && last;

    always_comb begin
        state_nxt = state;
        if (cmd_stop) begin
            state_nxt = IDLE;
        end else if (cmd_start) begin
            state_nxt = WAIT_STEP;                          // Also restarts mid-play
        end else begin
            case (state)
                IDLE:      state_nxt = IDLE;
                WAIT_STEP: if (step_req) state_nxt = READ;
                READ:      state_nxt = LATCH;               // Memory answers next cycle
                LATCH:     state_nxt = DECODE;
                DECODE:    state_nxt = (last && !repeat_en) ? IDLE : WAIT_STEP;
                default:   state_nxt = IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign busy      = (state != IDLE);
    assign mem_rd    = (state == READ);
    assign latch     = (state == LATCH);
    assign dec_en    = (state == DECODE);
    assign addr_adv  = (state == DECODE);
    assign addr_load = cmd_start;

    // Clear on any start or stop, and at a repeat wrap
    assign dec_clr      = cmd_start | cmd_stop | (at_end & repeat_en);
    assign end_flag_set = at_end & ~repeat_en & ~cmd_stop;

endmodule

`default_nettype wire

// File: hw/adpcmb_decoder.sv
//**********************************************************************
// Delta-T ADPCM decoder with adaptive step and panned outputs.
// Latches the selected nibble, updates accumulator and step on dec_en
// and registers the panned sample at every tick while playing.
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module adpcmb_decoder
    import adpcmb_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic [7:0] mem_data,
    input  wire logic       low_nib,
    input  wire logic       latch,
    input  wire logic       dec_en,
    input  wire logic       dec_clr,
    input  wire logic       tick,
    input  wire logic       busy,
    input  wire logic [1:0] pan,
    output pcm_t            pcm_l,
    output pcm_t            pcm_r,
    output logic            pcm_valid
);

    nibble_t            nib;
    logic [2:0]         mag;
    pcm_t               acc;
    step_t              step;
    logic [19:0]        diff_prod;      // (2*mag+1) * step
    logic [16:0]        diff;
    logic signed [17:0] acc_sum;
    pcm_t               acc_nxt;
    logic [23:0]        step_prod;
    logic [17:0]        step_scaled;
    step_t              step_nxt;

    // Nibble capture, high nibble at even addresses
    always_ff @(posedge clk) begin
        if (latch) begin
            nib <= low_nib ? mem_data[3:0] : mem_data[7:4];
        end
    end

    assign mag = nib[2:0];

    always_comb begin
        diff_prod = 20'({mag, 1'b1}) * 20'(step);
        diff      = diff_prod[19:3];                        // Divide by 8, truncated
        if (nib[3]) begin
            acc_sum = 18'(acc) - $signed({1'b0, diff});
        end else begin
            acc_sum = 18'(acc) + $signed({1'b0, diff});
        end
        if (acc_sum > 18'sd32767) begin
            acc_nxt = 16'sh7FFF;
        end else if (acc_sum < -18'sd32768) begin
            acc_nxt = 16'sh8000;
        end else begin
            acc_nxt = acc_sum[15:0];
        end

        step_prod   = 24'(step) * 24'(STEP_MULT[mag]);
        step_scaled = step_prod[23:6];                      // Over 64
        if (step_scaled < 18'(STEP_MIN)) begin
            step_nxt = STEP_MIN;
        end else if (step_scaled > 18'(STEP_MAX)) begin
            step_nxt = STEP_MAX;
        end else begin
            step_nxt = step_scaled[15:0];
        end
    end

    // Accumulator and step, clear wins over a decode
    always_ff @(posedge clk) begin
        if (rst || dec_clr) begin
            acc  <= '0;
            step <= STEP_INIT;
        end else if (dec_en) begin
            acc  <= acc_nxt;
            step <= step_nxt;
        end
    end

    // Output stage samples the accumulator before a pending decode
    always_ff @(posedge clk) begin
        if (rst || dec_clr) begin
            pcm_l     <= '0;
            pcm_r     <= '0;
            pcm_valid <= 1'b0;
        end else if (tick && busy) begin
            pcm_l     <= pan[1] ? acc : '0;                 // Left
            pcm_r     <= pan[0] ? acc : '0;                 // Right
            pcm_valid <= 1'b1;
        end else begin
            pcm_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: hw/adpcmb_top.sv
//**********************************************************************
// ADPCM-B channel top level. Connects the APB register block, timer,
// address counter, playback FSM and decoder. The sample memory is
// external with a fixed one-cycle read latency.
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module adpcmb_top
    import adpcmb_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire apb_req_s   apb_req,
    output apb_rsp_s        apb_rsp,
    output logic            mem_rd,
    output addr_t           mem_addr,
    input  wire logic [7:0] mem_data,
    output pcm_t            pcm_l,
    output pcm_t            pcm_r,
    output logic            pcm_valid
);

    chan_cfg_s cfg;
    logic      cmd_start;
    logic      cmd_stop;
    logic      busy;
    logic      end_flag_set;
    logic      tick;
    logic      step_req;
    logic      last;
    logic      low_nib;
    logic      latch;
    logic      dec_en;
    logic      dec_clr;
    logic      addr_load;
    logic      addr_adv;

    adpcmb_regs u_regs (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .apb_req      ( apb_req      ),
        .apb_rsp      ( apb_rsp      ),
        .busy         ( busy         ),
        .end_flag_set ( end_flag_set ),
        .cfg          ( cfg          ),
        .cmd_start    ( cmd_start    ),
        .cmd_stop     ( cmd_stop     )
    );

    adpcmb_step_timer u_timer (
        .clk       ( clk         ),
        .rst       ( rst         ),
        .rate      ( cfg.rate    ),
        .delta_n   ( cfg.delta_n ),
        .busy      ( busy        ),
        .cmd_start ( cmd_start   ),
        .tick      ( tick        ),
        .step_req  ( step_req    )
    );

    adpcmb_addr_gen u_addr (
        .clk        ( clk            ),
        .rst        ( rst            ),
        .start_addr ( cfg.start_addr ),
        .end_addr   ( cfg.end_addr   ),
        .load       ( addr_load      ),
        .adv        ( addr_adv       ),
        .mem_addr   ( mem_addr       ),
        .low_nib    ( low_nib        ),
        .last       ( last           )
    );

    adpcmb_ctrl u_ctrl (
        .clk          ( clk           ),
        .rst          ( rst           ),
        .cmd_start    ( cmd_start     ),
        .cmd_stop     ( cmd_stop      ),
        .repeat_en    ( cfg.repeat_en ),
        .step_req     ( step_req      ),
        .last         ( last          ),
        .busy         ( busy          ),
        .mem_rd       ( mem_rd        ),
        .latch        ( latch         ),
        .dec_en       ( dec_en        ),
        .dec_clr      ( dec_clr       ),
        .addr_load    ( addr_load     ),
        .addr_adv     ( addr_adv      ),
        .end_flag_set ( end_flag_set  )
    );

    adpcmb_decoder u_dec (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .mem_data  ( mem_data  ),
        .low_nib   ( low_nib   ),
        .latch     ( latch     ),
        .dec_en    ( dec_en    ),
        .dec_clr   ( dec_clr   ),
        .tick      ( tick      ),
        .busy      ( busy      ),
        .pan       ( cfg.pan   ),
        .pcm_l     ( pcm_l     ),
        .pcm_r     ( pcm_r     ),
        .pcm_valid ( pcm_valid )
    );

endmodule

`default_nettype wire

// File: tb/adpcmb_sva.sv
//**********************************************************************
// Concurrent checks on the channel, bound into the top level.
// Covers the memory read strobe, the APB error timing and the
// relation between output samples and the busy state.
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module adpcmb_sva
    import adpcmb_pkg::*;
(
    input wire logic     clk,
    input wire logic     rst,
    input wire logic     mem_rd,
    input wire apb_req_s apb_req,
    input wire apb_rsp_s apb_rsp,
    input wire logic     busy,
    input wire logic     pcm_valid
);

    // One read per nibble, never back to back
    mem_rd_single: assert property (@(posedge clk) disable iff (rst)
        mem_rd |=> !mem_rd)
        else $error("mem_rd high for two cycles in a row");

    slverr_in_access: assert property (@(posedge clk) disable iff (rst)
        apb_rsp.pslverr |-> (apb_req.psel && apb_req.penable))
        else $error("pslverr outside an APB access phase");

    // Sample registered from a tick one cycle earlier
    valid_when_busy: assert property (@(posedge clk) disable iff (rst)
        $rose(pcm_valid) |-> $past(busy))
        else $error("pcm_valid rose while the channel was idle");

endmodule

bind adpcmb_top adpcmb_sva u_sva (
    .clk       ( clk       ),
    .rst       ( rst       ),
    .mem_rd    ( mem_rd    ),
    .apb_req   ( apb_req   ),
    .apb_rsp   ( apb_rsp   ),
    .busy      ( busy      ),
    .pcm_valid ( pcm_valid )
);

`default_nettype wire

// File: tb/adpcmb_tb.sv
//**********************************************************************
// Testbench for the ADPCM-B channel. Programs the channel over APB,
// serves the sample memory and checks every output sample against a
// reference delta-T decoder fed with the nibbles that the DUT fetched.
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module adpcmb_tb
    import adpcmb_pkg::*;
();

    localparam int MAX_RATE    = 12;                        // Slowest divider used
    localparam int WATCH_TICKS = 17 + 32 + 20 + 40;         // Ticks of tests 2 to 5
    localparam int WATCH_NS    = 40 * WATCH_TICKS * MAX_RATE * 2;

    logic         clk = 1'b0;
    logic         rst = 1'b1;
    apb_req_s     apb_req = '0;
    apb_rsp_s     apb_rsp;
    logic         mem_rd;
    addr_t        mem_addr;
    logic [7:0]   mem_data = 8'h00;
    pcm_t         pcm_l;
    pcm_t         pcm_r;
    logic         pcm_valid;

    logic [7:0]   mem [0:255];                              // Sample memory model
    int           seed = 72;
    logic         rd_seen = 1'b0;
    addr_t        rd_addr = '0;

    // Channel setup as programmed by the running test
    addr_t        t_start = '0;
    addr_t        t_end = '0;
    logic [1:0]   t_pan = '0;
    logic         t_repeat = 1'b0;

    int           m_acc = 0;                                // Reference accumulator
    int           m_step = 127;
    nibble_addr_t exp_nib = '0;                             // Next nibble expected
    int           n_rd = 0;
    int           n_valid = 0;
    int           n_wrap = 0;                               // Fetches of the end nibble
    int           rd0;
    int           v0;
    int           drd;
    int           dv;
    logic [15:0]  rdata;
    logic         err;

    always #20 clk = ~clk;

    adpcmb_top uut (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .apb_req   ( apb_req   ),
        .apb_rsp   ( apb_rsp   ),
        .mem_rd    ( mem_rd    ),
        .mem_addr  ( mem_addr  ),
        .mem_data  ( mem_data  ),
        .pcm_l     ( pcm_l     ),
        .pcm_r     ( pcm_r     ),
        .pcm_valid ( pcm_valid )
    );

    // Delta-T rule giving {new accumulator, new step}
    function automatic logic [31:0] ref_decode(input nibble_t code, input int acc,
                                               input int step);
        int mag;
        int mult;
        int diff;
        int acc_n;
        int step_n;
        mag = int'(code[2:0]);
        case (mag)
            0, 1, 2, 3: mult = 57;
            4:          mult = 77;
            5:          mult = 102;
            6:          mult = 128;
            default:    mult = 153;
        endcase
        diff  = ((2 * mag + 1) * step) / 8;
        acc_n = code[3] ? acc - diff : acc + diff;
        if (acc_n > 32767) begin
            acc_n = 32767;
        end else if (acc_n < -32768) begin
            acc_n = -32768;
        end
        step_n = (step * mult) / 64;
        if (step_n < 127) begin
            step_n = 127;
        end else if (step_n > 24576) begin
            step_n = 24576;
        end
        return {acc_n[15:0], step_n[15:0]};
    endfunction

    function automatic logic [15:0] panned(input int acc, input logic en);
        return en ? 16'(acc) : 16'h0000;
    endfunction

    task automatic stop_fail();
        $display("** FAIL **");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_fail(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        stop_fail();
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [15:0] data,
                             output logic slverr);
        @(posedge clk);
        #1;
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;                             // Access phase
        @(negedge clk);
        slverr = apb_rsp.pslverr;
        assert (apb_rsp.pready) else check_fail("pready low in write access phase");
        @(posedge clk);
        #1;
        apb_req = '0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [15:0] data,
                            output logic slverr);
        @(posedge clk);
        #1;
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 16'h0};
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        @(negedge clk);
        data   = apb_rsp.prdata;                            // Valid in access phase
        slverr = apb_rsp.pslverr;
        assert (apb_rsp.pready) else check_fail("pready low in read access phase");
        @(posedge clk);
        #1;
        apb_req = '0;
    endtask

    task automatic reg_write(input logic [7:0] addr, input logic [15:0] data);
        logic slverr;
        apb_write(addr, data, slverr);
        assert (!slverr) else check_fail($sformatf("pslverr on write to %h", addr));
    endtask

    task automatic reg_check(input logic [7:0] addr, input logic [15:0] exp);
        logic [15:0] data;
        logic        slverr;
        apb_read(addr, data, slverr);
        assert (!slverr && data == exp)
            else check_fail($sformatf("reg %h read %h err %b, expected %h",
                                      addr, data, slverr, exp));
    endtask

    task automatic configure(input addr_t s, input addr_t e, input delta_n_t dn,
                             input rate_t rt, input logic [1:0] pan);
        t_start = s;
        t_end   = e;
        t_pan   = pan;
        reg_write(REG_START, s);
        reg_write(REG_END, e);
        reg_write(REG_DELTA_N, dn);
        reg_write(REG_RATE, rt);
        reg_write(REG_PAN, {14'd0, pan});
    endtask

    task automatic start_play(input logic rep);
        t_repeat = rep;
        reg_write(REG_CTRL, {13'd0, 1'b0, rep, 1'b1});
    endtask

    // Polls STATUS until the end flag shows up
    task automatic wait_end();
        logic [15:0] st;
        logic        slverr;
        st = '0;
        while (!st[1]) begin
            apb_read(REG_STATUS, st, slverr);
        end
    endtask

    always @(negedge clk) begin
        rd_seen <= mem_rd;
        rd_addr <= mem_addr;
    end

    always @(posedge clk) begin
        #1;
        if (rd_seen) begin
            mem_data = mem[rd_addr[7:0]];                   // One cycle after mem_rd
        end
    end

    // Model and compare mid-cycle where outputs are settled
    always @(negedge clk) begin
        logic [7:0]  byte_v;
        nibble_t     code;
        logic [31:0] res;
        if (!rst) begin
            if (pcm_valid) begin                            // Compare before this cycle's fetch
                n_valid = n_valid + 1;
                assert (pcm_l == panned(m_acc, t_pan[1]))
                    else check_fail($sformatf("pcm_l %h, model %h",
                                              pcm_l, panned(m_acc, t_pan[1])));
                assert (pcm_r == panned(m_acc, t_pan[0]))
                    else check_fail($sformatf("pcm_r %h, model %h",
                                              pcm_r, panned(m_acc, t_pan[0])));
            end
            if (mem_rd) begin
                n_rd = n_rd + 1;
                assert (mem_addr == exp_nib[16:1])
                    else check_fail($sformatf("mem_addr %h, expected %h",
                                              mem_addr, exp_nib[16:1]));
                byte_v = mem[mem_addr[7:0]];
                code   = exp_nib[0] ? byte_v[3:0] : byte_v[7:4];    // High nibble first
                if (exp_nib == {t_end, 1'b1} && t_repeat) begin
                    m_acc  = 0;                             // Wrap restarts decoding
                    m_step = 127;
                end else begin
                    res    = ref_decode(code, m_acc, m_step);
                    m_acc  = int'($signed(res[31:16]));
                    m_step = int'(res[15:0]);
                end
                if (exp_nib == {t_end, 1'b1}) begin
                    exp_nib = {t_start, 1'b0};
                    n_wrap  = n_wrap + 1;
                end else begin
                    exp_nib = exp_nib + 17'd1;
                end
            end
            if (apb_req.psel && apb_req.penable && apb_req.pwrite &&
                apb_req.paddr == REG_CTRL && apb_req.pwdata[CTRL_START_BIT] &&
                !apb_req.pwdata[CTRL_STOP_BIT]) begin
                m_acc   = 0;                                // Start clears the model
                m_step  = 127;
                exp_nib = {t_start, 1'b0};
            end
        end
    end

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 8'($random(seed));
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // Register access
        reg_check(REG_STATUS, 16'h0000);
        reg_write(REG_PAN, 16'h0003);
        reg_write(REG_START, 16'h1234);
        reg_write(REG_END, 16'hBEEF);
        reg_write(REG_DELTA_N, 16'h5A5A);
        reg_write(REG_RATE, 16'h0123);
        reg_write(REG_CTRL, 16'h0002);                      // Repeat bit without start
        reg_check(REG_PAN, 16'h0003);
        reg_check(REG_START, 16'h1234);
        reg_check(REG_END, 16'hBEEF);
        reg_check(REG_DELTA_N, 16'h5A5A);
        reg_check(REG_RATE, 16'h0123);
        reg_check(REG_CTRL, 16'h0002);
        apb_read(8'h1C, rdata, err);
        assert (err) else check_fail("no pslverr on unmapped read");
        apb_write(REG_STATUS, 16'h0003, err);
        assert (err) else check_fail("no pslverr on STATUS write");

        // One-shot playback at full pitch
        configure(16'h0010, 16'h0017, 16'hFFFF, 16'd8, 2'b11);
        rd0 = n_rd;
        start_play(1'b0);
        wait_end();
        assert (n_rd - rd0 == 16)
            else check_fail($sformatf("%0d reads, expected 16", n_rd - rd0));
        reg_check(REG_STATUS, 16'h0002);
        rd0 = n_rd;
        repeat (40) @(posedge clk);
        assert (n_rd == rd0) else check_fail("mem_rd after end of sample");

        // Quarter pitch
        configure(16'h0020, 16'h0023, 16'h4000, 16'd12, 2'b11);
        rd0 = n_rd;
        v0  = n_valid;
        start_play(1'b0);
        wait_end();
        drd = n_rd - rd0;
        dv  = n_valid - v0;
        assert (drd * 4 >= dv - 4 && drd * 4 <= dv + 4)
            else check_fail($sformatf("%0d reads for %0d samples", drd, dv));

        // Repeat with left pan only
        configure(16'h0030, 16'h0033, 16'hFFFF, 16'd8, 2'b10);
        v0 = n_wrap;
        start_play(1'b1);
        while (n_wrap < v0 + 2) @(posedge clk);
        rd0 = n_rd;
        while (n_rd < rd0 + 3) @(posedge clk);
        reg_write(REG_CTRL, 16'h0004);
        reg_check(REG_STATUS, 16'h0000);

        // Stop mid-sample and play again
        configure(16'h0040, 16'h004F, 16'hFFFF, 16'd8, 2'b11);
        rd0 = n_rd;
        start_play(1'b0);
        while (n_rd < rd0 + 6) @(posedge clk);
        reg_write(REG_CTRL, 16'h0004);
        @(negedge clk);
        assert (pcm_l == 16'h0 && pcm_r == 16'h0)
            else check_fail($sformatf("outputs %h %h after stop", pcm_l, pcm_r));
        reg_check(REG_STATUS, 16'h0000);
        rd0 = n_rd;
        repeat (40) @(posedge clk);
        assert (n_rd == rd0) else check_fail("mem_rd after stop");
        start_play(1'b0);
        wait_end();
        assert (n_rd - rd0 == 32)
            else check_fail($sformatf("%0d reads, expected 32", n_rd - rd0));

        $display("** PASS **");
        $finish;
    end

    initial begin
        #(WATCH_NS);
        $display("Timeout: the tests did not complete within %0d ns", WATCH_NS);
        stop_fail();
    end

endmodule

`default_nettype wire

// File: flist.f
hw/adpcmb_pkg.sv
hw/adpcmb_regs.sv
hw/adpcmb_step_timer.sv
hw/adpcmb_addr_gen.sv
hw/adpcmb_ctrl.sv
hw/adpcmb_decoder.sv
hw/adpcmb_top.sv
tb/adpcmb_sva.sv
tb/adpcmb_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the ADPCM-B channel testbench with Verilator, runs it and
# searches the output for the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module adpcmb_tb -f flist.f -o adpcmb_sim \
    && ./obj_dir/adpcmb_sim | tee /dev/stderr | grep -qF -- "** PASS **" \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed"; exit 1; }
